// ==== src.f ====
verilog/bus_pkg.sv
verilog/dev_pkg.sv
verilog/bus_stage_if.sv
verilog/bus_capture.sv
verilog/bus_decode.sv
verilog/io_regs.sv
verilog/bus_dispatch.sv
verilog/bus_respond.sv
verilog/busint.sv
tb/busint_mem_model.sv
tb/tb_busint.sv

// ==== run.sh ====
#!/bin/sh
# build the busint testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f src.f --top-module tb_busint -Mdir obj_dir -o tb_busint

./obj_dir/tb_busint | tee sim.log

if grep -q "Test FAILED" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
echo "simulation finished without failure"

// ==== tb/tb_busint.sv ====
// testbench top with clock, reset, cpu stimulus, assertions and error summary for busint
`timescale 1ns/1ps

module tb_busint;

   localparam logic [6:0]  vram_region = bus_pkg::VRAM_REGION_DEF;
   localparam logic [13:0] io_page     = bus_pkg::IO_PAGE_DEF;
   localparam int n_sdram     = 12;   // writes, then reads of the same words
   localparam int n_vram      = 6;
   localparam int n_io        = 12;
   localparam int max_delay   = 4;    // longest ready or done wait in the model
   localparam int num_req     = 2 * n_sdram + 2 * n_vram + n_io;
   localparam int cycle_limit = 40 * num_req * max_delay;

   localparam logic [1:0] ph_none  = 2'd0;
   localparam logic [1:0] ph_sdram = 2'd1;
   localparam logic [1:0] ph_vram  = 2'd2;
   localparam logic [1:0] ph_io    = 2'd3;

   logic        clk, rst_n;
   logic        req, write, load, ack;
   logic [21:0] addr;
   logic [31:0] datain, dataout;
   logic [21:0] sdram_addr;
   logic [31:0] sdram_data_out, sdram_data_in;
   logic        sdram_req, sdram_write, sdram_ready, sdram_done;
   logic [14:0] vram_addr;
   logic [31:0] vram_data_out, vram_data_in;
   logic        vram_req, vram_write, vram_ready, vram_done;
   logic [15:0] kb_data, spy_in, spy_out;
   logic        kb_ready, ms_ready, promdisable, interrupt;
   logic [11:0] ms_x, ms_y;
   logic [2:0]  ms_button;

   int          errors;
   int          issued;               // requests raised
   int          acks;
   int          cycles;
   logic [1:0]  phase;                // which target the stimulus aims at
   logic        tb_out;               // request accepted and not yet acked
   logic        accept_tb;
   logic        io_access;
   logic [31:0] exp_rdata;
   logic        io_known;             // io side outputs settled
   logic        exp_int, exp_prom;
   logic [15:0] exp_spy;
   logic [31:0] sdram_ref [logic [21:0]];
   logic [31:0] vram_ref  [logic [14:0]];

   busint #(.VRAM_REGION(vram_region), .IO_PAGE(io_page)) busint_inst (.cpu_clk(clk), .*);

   busint_mem_model #(.max_delay(max_delay)) mem_model_inst (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;   // 40 ns period
   end

   ////////////////////////////////////////
   // accept and ack bookkeeping
   ////////////////////////////////////////

   assign accept_tb = req && !tb_out;            // first edge with req and nothing open
   assign io_access = req && (phase == ph_io);

   always @(posedge clk) begin
      if (!rst_n)
         tb_out <= 1'b0;
      else if (accept_tb)
         tb_out <= 1'b1;
      else if (ack)
         tb_out <= 1'b0;                         // ack closes it
      if (rst_n && ack)
         acks <= acks + 1;
   end

   // hang guard
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: %0d cycles passed, %0d of %0d requests acked", cycles, acks, num_req);
         $display("Test FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // assertions
   ////////////////////////////////////////

   assert property (@(posedge clk) !rst_n |=>
         {ack, load, sdram_req, vram_req, interrupt, promdisable} == 6'b0)
      else begin
         errors++;
         $display("error %0t %s got %b expected %b", $time,
                  "ack/load/sdram_req/vram_req/interrupt/promdisable",
                  $sampled({ack, load, sdram_req, vram_req, interrupt, promdisable}), 6'b0);
      end
   assert property (@(posedge clk) !rst_n |=> (dataout == 32'd0 && spy_out == 16'd0))
      else begin
         errors++;
         $display("error %0t dataout/spy_out got %h/%h expected 0/0",
                  $time, $sampled(dataout), $sampled(spy_out));
      end

   assert property (@(posedge clk) disable iff (!rst_n) load |-> dataout == exp_rdata)
      else begin
         errors++;
         $display("error %0t dataout got %h expected %h",
                  $time, $sampled(dataout), $sampled(exp_rdata));
      end
   assert property (@(posedge clk) disable iff (!rst_n) ack |-> load == !write)
      else begin
         errors++;
         $display("error %0t load got %b expected %b", $time, $sampled(load), !$sampled(write));
      end
   assert property (@(posedge clk) disable iff (!rst_n) load |-> ack)
      else begin
         errors++;
         $display("load pulsed without ack at %0t", $time);
      end
   assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
      else begin
         errors++;
         $display("ack longer than one cycle at %0t", $time);
      end
   assert property (@(posedge clk) disable iff (!rst_n) ack |-> tb_out)
      else begin
         errors++;
         $display("ack with no request outstanding at %0t", $time);
      end

   // fixed 3 stage latency for io
   assert property (@(posedge clk) disable iff (!rst_n)
         (ack && io_access) |-> $past(accept_tb, 4))
      else begin
         errors++;
         $display("io ack came early or late, not 3 cycles after accept, at %0t", $time);
      end
   assert property (@(posedge clk) disable iff (!rst_n)
         ($past(accept_tb, 4) && io_access) |-> ack)
      else begin
         errors++;
         $display("io ack missing 3 cycles after accept at %0t", $time);
      end

   // memory ports
   assert property (@(posedge clk) disable iff (!rst_n) sdram_req |-> sdram_addr == addr)
      else begin
         errors++;
         $display("error %0t sdram_addr got %h expected %h",
                  $time, $sampled(sdram_addr), $sampled(addr));
      end
   assert property (@(posedge clk) disable iff (!rst_n) vram_req |-> vram_addr == addr[14:0])
      else begin
         errors++;
         $display("error %0t vram_addr got %h expected %h",
                  $time, $sampled(vram_addr), $sampled(addr[14:0]));
      end
   assert property (@(posedge clk) disable iff (!rst_n) phase != ph_vram |-> !vram_req)
      else begin
         errors++;
         $display("error %0t vram_req got 1 expected 0", $time);
      end
   assert property (@(posedge clk) disable iff (!rst_n) phase != ph_sdram |-> !sdram_req)
      else begin
         errors++;
         $display("error %0t sdram_req got 1 expected 0", $time);
      end

   // io outputs once settled
   assert property (@(posedge clk) disable iff (!rst_n) io_known |-> interrupt == exp_int)
      else begin
         errors++;
         $display("error %0t interrupt got %b expected %b",
                  $time, $sampled(interrupt), $sampled(exp_int));
      end
   assert property (@(posedge clk) disable iff (!rst_n) io_known |-> spy_out == exp_spy)
      else begin
         errors++;
         $display("error %0t spy_out got %h expected %h",
                  $time, $sampled(spy_out), $sampled(exp_spy));
      end
   assert property (@(posedge clk) disable iff (!rst_n) io_known |-> promdisable == exp_prom)
      else begin
         errors++;
         $display("error %0t promdisable got %b expected %b",
                  $time, $sampled(promdisable), $sampled(exp_prom));
      end

   ////////////////////////////////////////
   // cpu side helpers
   ////////////////////////////////////////

   // one request, held until ack
   task automatic cpu_access(input logic wr, input logic [21:0] a, input logic [31:0] d,
                             input logic [31:0] rd_exp);
      @(posedge clk);
      req       <= 1'b1;
      write     <= wr;
      addr      <= a;
      datain    <= d;
      exp_rdata <= rd_exp;
      issued++;
      do begin
         @(posedge clk);
      end while (!ack);
      req <= 1'b0;
   endtask

   function automatic logic [21:0] io_word(input logic [3:0] dev, input logic [3:0] rg);
      return {io_page, dev, rg};
   endfunction

   // any word outside the vram window and the io page
   function automatic logic [21:0] random_sdram_addr();
      logic [31:0] r;
      r = $urandom;
      while (r[21:15] == vram_region || r[21:8] == io_page)
         r = $urandom;
      return r[21:0];
   endfunction

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   initial begin
      logic [21:0] sa [n_sdram];
      logic [14:0] va [n_vram];
      logic [31:0] r;
      logic [31:0] d;
      void'($urandom(16335));
      rst_n     = 1'b0;
      req       = 1'b0;
      write     = 1'b0;
      addr      = 22'd0;
      datain    = 32'd0;
      kb_data   = 16'd0;
      kb_ready  = 1'b0;
      ms_x      = 12'd0;
      ms_y      = 12'd0;
      ms_button = 3'd0;
      ms_ready  = 1'b0;
      spy_in    = 16'd0;
      errors    = 0;
      issued    = 0;
      acks      = 0;
      cycles    = 0;
      phase     = ph_none;
      exp_rdata = 32'd0;
      io_known  = 1'b1;
      exp_int   = 1'b0;
      exp_prom  = 1'b0;
      exp_spy   = 16'd0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;

      // sdram write then read back
      phase <= ph_sdram;
      for (int i = 0; i < n_sdram; i++) begin
         sa[i] = random_sdram_addr();
         d = $urandom;
         sdram_ref[sa[i]] = d;                  // last write wins on repeats
         cpu_access(1'b1, sa[i], d, 32'd0);
      end
      for (int i = 0; i < n_sdram; i++)
         cpu_access(1'b0, sa[i], 32'd0, sdram_ref[sa[i]]);

      // vram window, offset only on the port
      phase <= ph_vram;
      for (int i = 0; i < n_vram; i++) begin
         r = $urandom;
         va[i] = r[14:0];
         d = $urandom;
         vram_ref[va[i]] = d;
         cpu_access(1'b1, {vram_region, va[i]}, d, 32'd0);
      end
      for (int i = 0; i < n_vram; i++)
         cpu_access(1'b0, {vram_region, va[i]}, 32'd0, vram_ref[va[i]]);

      // keyboard and interrupt
      phase <= ph_io;
      cpu_access(1'b1, io_word(dev_pkg::dev_ctrl, dev_pkg::reg_ctrl_int), 32'd1, 32'd0);
      cpu_access(1'b0, io_word(dev_pkg::dev_ctrl, dev_pkg::reg_ctrl_int), 32'd0, 32'd1);
      r = $urandom;
      @(posedge clk);
      io_known <= 1'b0;
      kb_data  <= r[15:0];
      kb_ready <= 1'b1;                         // one cycle key strobe
      @(posedge clk);
      kb_ready <= 1'b0;
      @(posedge clk);
      exp_int  <= 1'b1;
      io_known <= 1'b1;
      cpu_access(1'b0, io_word(dev_pkg::dev_kbd, dev_pkg::reg_kbd_status), 32'd0,
                 32'd1 << dev_pkg::stat_kb_ready);
      io_known <= 1'b0;                         // data read drops the interrupt
      cpu_access(1'b0, io_word(dev_pkg::dev_kbd, dev_pkg::reg_kbd_data), 32'd0,
                 {16'd0, r[15:0]});
      exp_int  <= 1'b0;
      io_known <= 1'b1;
      cpu_access(1'b0, io_word(dev_pkg::dev_kbd, dev_pkg::reg_kbd_status), 32'd0, 32'd0);

      // spy registers
      r = $urandom;
      io_known <= 1'b0;
      cpu_access(1'b1, io_word(dev_pkg::dev_spy, dev_pkg::reg_spy_out), r, 32'd0);
      exp_spy  <= r[15:0];
      io_known <= 1'b1;
      cpu_access(1'b0, io_word(dev_pkg::dev_spy, dev_pkg::reg_spy_out), 32'd0, {16'd0, r[15:0]});
      r = $urandom;
      spy_in <= r[31:16];
      cpu_access(1'b0, io_word(dev_pkg::dev_spy, dev_pkg::reg_spy_in), 32'd0, {16'd0, r[31:16]});

      // boot control, promdisable is sticky
      io_known <= 1'b0;
      cpu_access(1'b1, io_word(dev_pkg::dev_ctrl, dev_pkg::reg_ctrl_boot), 32'd1, 32'd0);
      exp_prom <= 1'b1;
      io_known <= 1'b1;
      cpu_access(1'b1, io_word(dev_pkg::dev_ctrl, dev_pkg::reg_ctrl_boot), 32'd0, 32'd0);
      cpu_access(1'b0, io_word(dev_pkg::dev_ctrl, dev_pkg::reg_ctrl_boot), 32'd0, 32'd1);
      cpu_access(1'b0, io_word(4'hf, 4'h0), 32'd0, 32'd0);   // unknown device reads zero

      phase <= ph_none;
      repeat (4) @(posedge clk);
      assert (acks == issued && issued == num_req)
         else begin
            errors++;
            $display("error %0t ack count got %0d expected %0d", $time, acks, issued);
         end
      $display("summary: %0d errors, %0d requests, %0d acks", errors, issued, acks);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// ==== tb/busint_mem_model.sv ====
// sdram and vram responder models with word arrays and random ready and done delays
`timescale 1ns/1ps

module busint_mem_model #(
   parameter int max_delay = 4
) (
   input  logic        clk,
   input  logic [21:0] sdram_addr,
   input  logic [31:0] sdram_data_out,
   output logic [31:0] sdram_data_in,
   input  logic        sdram_req,
   input  logic        sdram_write,
   output logic        sdram_ready,
   output logic        sdram_done,
   input  logic [14:0] vram_addr,
   input  logic [31:0] vram_data_out,
   output logic [31:0] vram_data_in,
   input  logic        vram_req,
   input  logic        vram_write,
   output logic        vram_ready,
   output logic        vram_done
);

   logic [31:0] sdram_mem [logic [21:0]];
   logic [31:0] vram_mem  [logic [14:0]];

   ////////////////////////////////////////
   // sdram side
   ////////////////////////////////////////

   initial begin
      logic [21:0] a;
      int          d;
      sdram_ready   = 1'b0;
      sdram_done    = 1'b0;
      sdram_data_in = 32'd0;
      forever begin
         @(posedge clk);
         if (sdram_req) begin
            d = int'($urandom_range(max_delay, 0));
            repeat (d) @(posedge clk);
            a = sdram_addr;                        // held until ready
            if (sdram_write)
               sdram_mem[a] = sdram_data_out;
            sdram_ready <= 1'b1;
            @(posedge clk);
            sdram_ready <= 1'b0;
            d = int'($urandom_range(max_delay, 0));
            repeat (d) @(posedge clk);
            if (sdram_mem.exists(a))
               sdram_data_in <= sdram_mem[a];
            else
               sdram_data_in <= {10'h2b5, a};      // fill tracks the address
            sdram_done <= 1'b1;
            @(posedge clk);
            sdram_done <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////
   // vram side
   ////////////////////////////////////////

   initial begin
      logic [14:0] a;
      int          d;
      vram_ready   = 1'b0;
      vram_done    = 1'b0;
      vram_data_in = 32'd0;
      forever begin
         @(posedge clk);
         if (vram_req) begin
            d = int'($urandom_range(max_delay, 0));
            repeat (d) @(posedge clk);
            a = vram_addr;
            if (vram_write)
               vram_mem[a] = vram_data_out;
            vram_ready <= 1'b1;
            @(posedge clk);
            vram_ready <= 1'b0;
            d = int'($urandom_range(max_delay, 0));
            repeat (d) @(posedge clk);
            if (vram_mem.exists(a))
               vram_data_in <= vram_mem[a];
            else
               vram_data_in <= {17'h1b2c3, a};
            vram_done <= 1'b1;                     // read data valid with done
            @(posedge clk);
            vram_done <= 1'b0;
         end
      end
   end

endmodule

// ==== verilog/busint.sv ====
// cpu bus interface top level with pipeline stages and stage links
`timescale 1ns/1ps

module busint #(
   parameter logic [6:0]  VRAM_REGION = bus_pkg::VRAM_REGION_DEF,
   parameter logic [13:0] IO_PAGE     = bus_pkg::IO_PAGE_DEF
) (
   input  logic        cpu_clk,
   input  logic        rst_n,
   // cpu
   input  logic        req,
   input  logic        write,
   input  logic [21:0] addr,
   input  logic [31:0] datain,
   output logic [31:0] dataout,
   output logic        load,
   output logic        ack,
   // sdram
   output logic [21:0] sdram_addr,
   output logic [31:0] sdram_data_out,
   input  logic [31:0] sdram_data_in,
   output logic        sdram_req,
   output logic        sdram_write,
   input  logic        sdram_ready,
   input  logic        sdram_done,
   // vram
   output logic [14:0] vram_addr,
   output logic [31:0] vram_data_out,
   input  logic [31:0] vram_data_in,
   output logic        vram_req,
   output logic        vram_write,
   input  logic        vram_ready,
   input  logic        vram_done,
   // keyboard and mouse
   input  logic [15:0] kb_data,
   input  logic        kb_ready,
   input  logic [11:0] ms_x,
   input  logic [11:0] ms_y,
   input  logic [2:0]  ms_button,
   input  logic        ms_ready,
   // spy and boot control
   input  logic [15:0] spy_in,
   output logic [15:0] spy_out,
   output logic        promdisable,
   output logic        interrupt
);

   bus_stage_if cap_dec ();   // capture -> decode
   bus_stage_if dec_dsp ();   // decode -> dispatch
   bus_stage_if dsp_rsp ();   // dispatch -> respond

   bus_capture bus_capture_inst (
      .clk(cpu_clk), .rst_n(rst_n), .req(req), .write(write), .addr(addr),
      .datain(datain), .ack(ack), .out(cap_dec)
   );

   bus_decode #(.VRAM_REGION(VRAM_REGION), .IO_PAGE(IO_PAGE)) bus_decode_inst (
      .clk(cpu_clk), .rst_n(rst_n), .in(cap_dec), .out(dec_dsp)
   );

   bus_dispatch bus_dispatch_inst (
      .clk(cpu_clk), .rst_n(rst_n), .in(dec_dsp), .out(dsp_rsp),
      .sdram_addr(sdram_addr), .sdram_data_out(sdram_data_out),
      .sdram_data_in(sdram_data_in), .sdram_req(sdram_req),
      .sdram_write(sdram_write), .sdram_ready(sdram_ready), .sdram_done(sdram_done),
      .vram_addr(vram_addr), .vram_data_out(vram_data_out),
      .vram_data_in(vram_data_in), .vram_req(vram_req),
      .vram_write(vram_write), .vram_ready(vram_ready), .vram_done(vram_done),
      .kb_data(kb_data), .kb_ready(kb_ready),
      .ms_x(ms_x), .ms_y(ms_y), .ms_button(ms_button), .ms_ready(ms_ready),
      .spy_in(spy_in), .spy_out(spy_out),
      .promdisable(promdisable), .interrupt(interrupt)
   );

   bus_respond bus_respond_inst (
      .clk(cpu_clk), .rst_n(rst_n), .in(dsp_rsp),
      .dataout(dataout), .load(load), .ack(ack)
   );

endmodule

// ==== verilog/bus_respond.sv ====
// respond stage with cpu side ack, load strobe and read data register
`timescale 1ns/1ps

module bus_respond (
   input  logic        clk,
   input  logic        rst_n,
   bus_stage_if.dst    in,
   output logic [31:0] dataout,
   output logic        load,
   output logic        ack
);

   logic take;

   // last stage never stalls
   assign in.ready = 1'b1;
   assign take     = in.valid;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack     <= 1'b0;
         load    <= 1'b0;
         dataout <= 32'd0;
      end else begin
         ack  <= take;                 // one cycle per item
         load <= take && !in.write;    // reads only
         if (take && !in.write)
            dataout <= in.rdata;       // good while load is high
      end
   end

endmodule

// ==== verilog/bus_dispatch.sv ====
// dispatch stage with sdram and vram handshakes, i/o register access and result to respond
`timescale 1ns/1ps

module bus_dispatch (
   input  logic        clk,
   input  logic        rst_n,
   bus_stage_if.dst    in,
   bus_stage_if.src    out,
   // sdram port
   output logic [21:0] sdram_addr,
   output logic [31:0] sdram_data_out,
   input  logic [31:0] sdram_data_in,
   output logic        sdram_req,
   output logic        sdram_write,
   input  logic        sdram_ready,
   input  logic        sdram_done,
   // vram port
   output logic [14:0] vram_addr,
   output logic [31:0] vram_data_out,
   input  logic [31:0] vram_data_in,
   output logic        vram_req,
   output logic        vram_write,
   input  logic        vram_ready,
   input  logic        vram_done,
   // i/o devices
   input  logic [15:0] kb_data,
   input  logic        kb_ready,
   input  logic [11:0] ms_x,
   input  logic [11:0] ms_y,
   input  logic [2:0]  ms_button,
   input  logic        ms_ready,
   input  logic [15:0] spy_in,
   output logic [15:0] spy_out,
   output logic        promdisable,
   output logic        interrupt
);

   ////////////////////////////////////////
   // fsm states
   ////////////////////////////////////////

   localparam logic [1:0] st_idle      = 2'd0;
   localparam logic [1:0] st_request   = 2'd1;  // req held until ready
   localparam logic [1:0] st_wait_done = 2'd2;
   localparam logic [1:0] st_hand_on   = 2'd3;  // result offered to respond

   logic [1:0]           state;
   bus_pkg::bus_addr_t   addr_q;
   logic                 write_q;
   logic [31:0]          wdata_q;
   bus_pkg::bus_target_e tgt_q;
   logic [31:0]          rdata_q;
   logic                 take;
   logic                 io_sel;
   logic [31:0]          io_rdata;
   logic                 is_sdram;
   logic                 is_vram;

   assign in.ready = (state == st_idle);
   assign take     = in.valid && in.ready;
   assign io_sel   = take && (in.target == bus_pkg::tgt_io);   // single cycle strobe

   assign is_sdram = (tgt_q == bus_pkg::tgt_sdram);
   assign is_vram  = (tgt_q == bus_pkg::tgt_vram);

   // external ports
   assign sdram_addr     = addr_q;
   assign sdram_data_out = wdata_q;
   assign sdram_req      = (state == st_request) && is_sdram;
   assign sdram_write    = sdram_req && write_q;
   assign vram_addr      = addr_q.mem.offset;
   assign vram_data_out  = wdata_q;
   assign vram_req       = (state == st_request) && is_vram;
   assign vram_write     = vram_req && write_q;

   // towards respond
   assign out.valid  = (state == st_hand_on);
   assign out.write  = write_q;
   assign out.addr   = addr_q;
   assign out.wdata  = wdata_q;
   assign out.target = tgt_q;
   assign out.rdata  = rdata_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               if (take)   // i/o done on this edge
                  state <= io_sel ? st_hand_on : st_request;
            end
            st_request: begin
               if ((is_sdram && sdram_ready) || (is_vram && vram_ready))
                  state <= st_wait_done;
            end
            st_wait_done: begin
               if ((is_sdram && sdram_done) || (is_vram && vram_done))
                  state <= st_hand_on;
            end
            default: begin
               if (out.ready)
                  state <= st_idle;
            end
         endcase
      end
   end

   // payload and read data
   always_ff @(posedge clk) begin
      if (take) begin
         addr_q  <= in.addr;
         write_q <= in.write;
         wdata_q <= in.wdata;
         tgt_q   <= in.target;
         rdata_q <= io_rdata;                 // only kept for i/o
      end else if (state == st_wait_done) begin
         if (is_sdram && sdram_done)
            rdata_q <= sdram_data_in;         // sampled on done edge
         else if (is_vram && vram_done)
            rdata_q <= vram_data_in;
      end
   end

   io_regs io_regs_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .sel         (io_sel),
      .write       (in.write),
      .dev_sel     (in.addr.io.dev_sel),
      .reg_sel     (in.addr.io.reg_sel),
      .wdata       (in.wdata),
      .rdata       (io_rdata),
      .kb_data     (kb_data),
      .kb_ready    (kb_ready),
      .ms_x        (ms_x),
      .ms_y        (ms_y),
      .ms_button   (ms_button),
      .ms_ready    (ms_ready),
      .spy_in      (spy_in),
      .spy_out     (spy_out),
      .promdisable (promdisable),
      .interrupt   (interrupt)
   );

endmodule

// ==== verilog/io_regs.sv ====
// keyboard, mouse, spy and control registers plus the keyboard interrupt
`timescale 1ns/1ps

module io_regs (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        sel,        // one cycle access strobe
   input  logic        write,
   input  logic [3:0]  dev_sel,
   input  logic [3:0]  reg_sel,
   input  logic [31:0] wdata,
   output logic [31:0] rdata,      // valid for current dev/reg
   input  logic [15:0] kb_data,
   input  logic        kb_ready,
   input  logic [11:0] ms_x,
   input  logic [11:0] ms_y,
   input  logic [2:0]  ms_button,
   input  logic        ms_ready,
   input  logic [15:0] spy_in,
   output logic [15:0] spy_out,
   output logic        promdisable,
   output logic        interrupt
);

   logic [15:0] kb_data_q;
   logic [11:0] ms_x_q;
   logic [11:0] ms_y_q;
   logic [2:0]  ms_btn_q;
   logic        kb_pend;   // unread key waiting
   logic        ms_pend;
   logic        int_en;
   logic        rd;
   logic        wr;

   assign rd        = sel && !write;
   assign wr        = sel && write;
   assign interrupt = kb_pend && int_en;

   ////////////////////////////////////////
   // read mux
   ////////////////////////////////////////

   always_comb begin
      rdata = '0;   // unknown regs read zero
      case (dev_sel)
         dev_pkg::dev_kbd: begin
            if (reg_sel == dev_pkg::reg_kbd_data)
               rdata = {16'd0, kb_data_q};
            else if (reg_sel == dev_pkg::reg_kbd_status) begin
               rdata[dev_pkg::stat_kb_ready] = kb_pend;
               rdata[dev_pkg::stat_ms_ready] = ms_pend;
            end
         end
         dev_pkg::dev_mouse: begin
            case (reg_sel)
               dev_pkg::reg_ms_x:      rdata = {20'd0, ms_x_q};
               dev_pkg::reg_ms_y:      rdata = {20'd0, ms_y_q};
               dev_pkg::reg_ms_button: rdata = {29'd0, ms_btn_q};
               default:                rdata = '0;
            endcase
         end
         dev_pkg::dev_spy: begin
            if (reg_sel == dev_pkg::reg_spy_out)
               rdata = {16'd0, spy_out};
            else if (reg_sel == dev_pkg::reg_spy_in)
               rdata = {16'd0, spy_in};
         end
         dev_pkg::dev_ctrl: begin
            if (reg_sel == dev_pkg::reg_ctrl_boot)
               rdata = {31'd0, promdisable};
            else if (reg_sel == dev_pkg::reg_ctrl_int)
               rdata = {31'd0, int_en};
         end
         default: rdata = '0;
      endcase
   end

   ////////////////////////////////////////
   // state and latches
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         kb_pend     <= 1'b0;
         ms_pend     <= 1'b0;
         int_en      <= 1'b0;
         promdisable <= 1'b0;
         spy_out     <= 16'd0;
      end else begin
         // new key wins over a clearing read
         if (kb_ready)
            kb_pend <= 1'b1;
         else if (rd && dev_sel == dev_pkg::dev_kbd && reg_sel == dev_pkg::reg_kbd_data)
            kb_pend <= 1'b0;

         if (ms_ready)
            ms_pend <= 1'b1;
         else if (rd && dev_sel == dev_pkg::dev_mouse && reg_sel == dev_pkg::reg_ms_button)
            ms_pend <= 1'b0;

         if (wr && dev_sel == dev_pkg::dev_spy && reg_sel == dev_pkg::reg_spy_out)
            spy_out <= wdata[15:0];
         if (wr && dev_sel == dev_pkg::dev_ctrl && reg_sel == dev_pkg::reg_ctrl_boot && wdata[0])
            promdisable <= 1'b1;   // sticky until reset
         if (wr && dev_sel == dev_pkg::dev_ctrl && reg_sel == dev_pkg::reg_ctrl_int)
            int_en <= wdata[0];
      end
   end

   // device values
   always_ff @(posedge clk) begin
      if (kb_ready)
         kb_data_q <= kb_data;
      if (ms_ready) begin
         ms_x_q   <= ms_x;
         ms_y_q   <= ms_y;
         ms_btn_q <= ms_button;
      end
   end

endmodule

// ==== verilog/bus_decode.sv ====
// decode stage with address decode into target and local address, one register stage
`timescale 1ns/1ps

module bus_decode #(
   parameter logic [6:0]  VRAM_REGION = bus_pkg::VRAM_REGION_DEF,
   parameter logic [13:0] IO_PAGE     = bus_pkg::IO_PAGE_DEF
) (
   input  logic     clk,
   input  logic     rst_n,
   bus_stage_if.dst in,
   bus_stage_if.src out
);

   bus_pkg::bus_target_e tgt_d;
   bus_pkg::bus_addr_t   addr_d;
   logic                 take;

   // one entry, frees as soon as dispatch takes it
   assign in.ready = !out.valid || out.ready;
   assign take     = in.valid && in.ready;

   ////////////////////////////////////////
   // decode
   ////////////////////////////////////////

   always_comb begin
      addr_d = in.addr;
      if (in.addr.io.io_page == IO_PAGE) begin
         tgt_d = bus_pkg::tgt_io;            // dev/reg fields stay
      end else if (in.addr.mem.region == VRAM_REGION) begin
         tgt_d = bus_pkg::tgt_vram;
         addr_d.mem.region = 7'd0;          // vram sees the offset only
      end else begin
         tgt_d = bus_pkg::tgt_sdram;        // full word address
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         out.valid <= 1'b0;
      else if (take)
         out.valid <= 1'b1;
      else if (out.ready)
         out.valid <= 1'b0;
   end

   // payload
   always_ff @(posedge clk) begin
      if (take) begin
         out.write  <= in.write;
         out.addr   <= addr_d;
         out.wdata  <= in.wdata;
         out.target <= tgt_d;
      end
   end

endmodule

// ==== verilog/bus_capture.sv ====
// capture stage that takes one cpu request into the pipeline
`timescale 1ns/1ps

module bus_capture (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        req,
   input  logic        write,
   input  logic [21:0] addr,
   input  logic [31:0] datain,
   input  logic        ack,      // from respond, ends the request
   bus_stage_if.src    out
);

   logic outstanding;   // request taken and not yet acked
   logic accept;

   // cpu holds req until ack so take it once only
   assign accept = req && !outstanding && !ack && (!out.valid || out.ready);

   // decode assigns the real target
   assign out.target = bus_pkg::tgt_sdram;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         outstanding <= 1'b0;
         out.valid   <= 1'b0;
      end else begin
         if (accept)
            outstanding <= 1'b1;
         else if (ack)
            outstanding <= 1'b0;   // cpu may drop req now

         if (accept)
            out.valid <= 1'b1;
         else if (out.ready)
            out.valid <= 1'b0;     // handed to decode
      end
   end

   // payload
   always_ff @(posedge clk) begin
      if (accept) begin
         out.write <= write;
         out.addr  <= addr;      // raw word, union view later
         out.wdata <= datain;
      end
   end

endmodule

// ==== verilog/bus_stage_if.sv ====
// one bus request with its handshake, passed between two pipeline stages
`timescale 1ns/1ps

interface bus_stage_if;

   logic                    valid;   // item present
   logic                    ready;   // taker can accept
   logic                    write;   // 1 = store
   bus_pkg::bus_addr_t      addr;
   logic [31:0]             wdata;
   bus_pkg::bus_target_e    target;
   logic [31:0]             rdata;   // only on dispatch -> respond

   // upstream side
   modport src (
      output valid, write, addr, wdata, target, rdata,
      input  ready
   );

   // downstream side
   modport dst (
      input  valid, write, addr, wdata, target, rdata,
      output ready
   );

endinterface

// ==== verilog/dev_pkg.sv ====
// i/o device numbers, register numbers and keyboard status bit positions
package dev_pkg;

   ////////////////////////////////////////
   // devices on the i/o page
   ////////////////////////////////////////

   localparam logic [3:0] dev_kbd   = 4'h0;
   localparam logic [3:0] dev_mouse = 4'h1;
   localparam logic [3:0] dev_spy   = 4'h2;
   localparam logic [3:0] dev_ctrl  = 4'h3;

   ////////////////////////////////////////
   // registers per device
   ////////////////////////////////////////

   localparam logic [3:0] reg_kbd_data   = 4'h0;  // read clears pending
   localparam logic [3:0] reg_kbd_status = 4'h1;

   localparam logic [3:0] reg_ms_x       = 4'h0;
   localparam logic [3:0] reg_ms_y       = 4'h1;
   localparam logic [3:0] reg_ms_button  = 4'h2;  // read clears mouse flag

   localparam logic [3:0] reg_spy_out    = 4'h0;  // read/write
   localparam logic [3:0] reg_spy_in     = 4'h1;  // read only

   localparam logic [3:0] reg_ctrl_boot  = 4'h0;  // bit 0 sets promdisable
   localparam logic [3:0] reg_ctrl_int   = 4'h1;  // bit 0 is interrupt enable

   // keyboard status bits
   localparam int stat_kb_ready = 0;
   localparam int stat_ms_ready = 1;

endpackage

// ==== verilog/bus_pkg.sv ====
// address map defaults, cpu address union and target codes for the bus interface
package bus_pkg;

   ////////////////////////////////////////
   // address map
   ////////////////////////////////////////

   // region number of the video memory window
   localparam logic [6:0]  VRAM_REGION_DEF = 7'h7e;
   // top page of the map holds the i/o registers
   localparam logic [13:0] IO_PAGE_DEF     = 14'h3fff;

   ////////////////////////////////////////
   // cpu word address, two views
   ////////////////////////////////////////

   // memory view
   typedef struct packed {
      logic [6:0]  region;   // picks sdram or vram
      logic [14:0] offset;   // word within region
   } mem_view_t;

   // i/o view of the same 22 bits
   typedef struct packed {
      logic [13:0] io_page;  // must match the i/o page
      logic [3:0]  dev_sel;  // device number
      logic [3:0]  reg_sel;  // register in device
   } io_view_t;

   typedef union packed {
      mem_view_t mem;
      io_view_t  io;
   } bus_addr_t;

   // where a request goes
   typedef enum logic [1:0] {
      tgt_sdram = 2'd0,
      tgt_vram  = 2'd1,
      tgt_io    = 2'd2
   } bus_target_e;

endpackage
